// ==== hw/pr_pkg.sv ====
package pr_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths and depths
	//////////////////////////////////////////////////////////////////////

	localparam int VERTEX_W          = 16;
	localparam int ADDR_W            = 16;
	localparam int RANK_W            = 32;
	localparam int COUNT_W           = 32;
	localparam int VERTEX_FIFO_DEPTH = 4;
	localparam int CMD_FIFO_DEPTH    = 8;
	// Also the limit on edge reads in flight
	localparam int EDGE_ID_DEPTH     = 4;

	//////////////////////////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////////////////////////

	typedef logic [VERTEX_W-1:0] vertex_id_t;

	typedef enum logic {
		RD_EDGE_JOB  = 1'b0,
		RD_EDGE_DATA = 1'b1
	} read_kind_t;

	typedef struct packed {
		vertex_id_t          id;
		logic [ADDR_W-1:0]   edge_base;
		logic [VERTEX_W-1:0] degree;
	} vertex_job_t;

	typedef struct packed {
		read_kind_t        kind;
		logic [ADDR_W-1:0] addr;
	} read_cmd_t;

endpackage

// ==== hw/cmd_port_if.sv ====
`timescale 1ns/1ps

interface cmd_port_if #(
	parameter int AW = 1
) ();
	logic          req;
	logic          ack;
	logic          kind;
	logic [AW-1:0] addr;

	// Command producer holds kind and addr while req is high
	modport source (output req, output kind, output addr, input ack);

	// Arbiter side
	modport sink (input req, input kind, input addr, output ack);

endinterface

// ==== hw/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
	parameter type T     = logic,
	parameter int  DEPTH = 4
) (
	input  logic clock,
	input  logic rstn,
	input  logic push,
	input  T     data_in,
	input  logic pop,
	output T     data_out,
	output logic empty,
	output logic full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	T                 mem [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] count;

	// Storage
	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CNT_W'(push) - CNT_W'(pop);
		end
	end

	// Head item is visible without a pop
	assign data_out = mem[rd_ptr];
	assign empty    = (count == '0);
	assign full     = (count == CNT_W'(DEPTH));

	assert property (@(posedge clock) disable iff (!rstn) !(push && full) && !(pop && empty))
		else $error("sync_fifo overflow or underflow");

endmodule

// ==== hw/vertex_job_control.sv ====
`timescale 1ns/1ps

module vertex_job_control
	import pr_pkg::*;
(
	input  logic                clock,
	input  logic                rstn,
	input  logic                vtx_req,
	input  vertex_id_t          vtx_id,
	input  logic [ADDR_W-1:0]   vtx_edge_base,
	input  logic [VERTEX_W-1:0] vtx_degree,
	input  logic                vertex_done,
	output logic                vtx_ack,
	output logic                start,
	output vertex_job_t         job
);

	vertex_job_t job_in;
	vertex_job_t job_head;
	logic        push;
	logic        pop;
	logic        empty;
	logic        full;
	logic        busy;

	assign job_in = '{id: vtx_id, edge_base: vtx_edge_base, degree: vtx_degree};

	//////////////////////////////////////////////////////////////////////
	// Intake handshake
	//////////////////////////////////////////////////////////////////////

	// Job enters the queue on the same edge that raises ack
	assign push = vtx_req && !vtx_ack && !full;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vtx_ack <= 1'b0;
		end else if (push) begin
			vtx_ack <= 1'b1;
		end else if (!vtx_req) begin
			vtx_ack <= 1'b0;
		end
	end

	sync_fifo #(
		.T    (vertex_job_t),
		.DEPTH(VERTEX_FIFO_DEPTH)
	) job_fifo_inst (
		.clock   (clock),
		.rstn    (rstn),
		.push    (push),
		.data_in (job_in),
		.pop     (pop),
		.data_out(job_head),
		.empty   (empty),
		.full    (full)
	);

	//////////////////////////////////////////////////////////////////////
	// Dispatch of one vertex at a time
	//////////////////////////////////////////////////////////////////////

	assign pop = !busy && !empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy  <= 1'b0;
			start <= 1'b0;
		end else begin
			start <= pop;
			if (pop) begin
				busy <= 1'b1;
			end else if (vertex_done) begin
				busy <= 1'b0;
			end
		end
	end

	// Held until the next dispatch
	always_ff @(posedge clock) begin
		if (pop) begin
			job <= job_head;
		end
	end

endmodule

// ==== hw/edge_job_control.sv ====
`timescale 1ns/1ps

module edge_job_control
	import pr_pkg::*;
(
	input  logic        clock,
	input  logic        rstn,
	input  logic        start,
	input  vertex_job_t job,
	input  logic        edge_id_pop,
	cmd_port_if.source  cmd
);

	localparam int CREDIT_W = $clog2(EDGE_ID_DEPTH + 1);

	logic                active;
	logic [VERTEX_W-1:0] idx;
	logic [CREDIT_W-1:0] credits;
	logic                launch;

	assign cmd.kind = RD_EDGE_JOB;

	// Next edge read once the last handshake is fully closed and a credit is free
	assign launch = active && (idx != job.degree) && !cmd.req && !cmd.ack &&
		(credits < CREDIT_W'(EDGE_ID_DEPTH));

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			active  <= 1'b0;
			idx     <= '0;
			cmd.req <= 1'b0;
			credits <= '0;
		end else begin
			if (start) begin
				active <= 1'b1;
				idx    <= '0;
			end else if (active && idx == job.degree) begin
				active <= 1'b0;
			end else if (launch) begin
				idx <= idx + 1'b1;
			end
			if (launch) begin
				cmd.req <= 1'b1;
			end else if (cmd.ack) begin
				cmd.req <= 1'b0;
			end
			// Credit taken at request and returned when the id leaves the buffer
			credits <= credits + CREDIT_W'(launch) - CREDIT_W'(edge_id_pop);
		end
	end

	always_ff @(posedge clock) begin
		if (launch) begin
			cmd.addr <= job.edge_base + ADDR_W'(idx);
		end
	end

	assert property (@(posedge clock) disable iff (!rstn)
		credits <= CREDIT_W'(EDGE_ID_DEPTH) && !(edge_id_pop && credits == '0))
		else $error("edge read credits out of range");

endmodule

// ==== hw/edge_data_control.sv ====
`timescale 1ns/1ps

module edge_data_control
	import pr_pkg::*;
(
	input  logic              clock,
	input  logic              rstn,
	input  logic              rsp_valid,
	input  read_kind_t        rsp_kind,
	input  logic [RANK_W-1:0] rsp_data,
	output logic              edge_id_pop,
	output logic              contrib_valid,
	output logic [RANK_W-1:0] contrib,
	cmd_port_if.source        cmd
);

	logic       id_push;
	logic       id_empty;
	logic       id_full;
	logic       data_rsp;
	vertex_id_t id_head;

	//////////////////////////////////////////////////////////////////////
	// Response routing by kind
	//////////////////////////////////////////////////////////////////////

	assign id_push  = rsp_valid && (rsp_kind == RD_EDGE_JOB);
	assign data_rsp = rsp_valid && (rsp_kind == RD_EDGE_DATA);

	// Neighbor id buffer with room guaranteed by the edge read credits
	sync_fifo #(
		.T    (vertex_id_t),
		.DEPTH(EDGE_ID_DEPTH)
	) edge_id_fifo_inst (
		.clock   (clock),
		.rstn    (rstn),
		.push    (id_push),
		.data_in (rsp_data[VERTEX_W-1:0]),
		.pop     (edge_id_pop),
		.data_out(id_head),
		.empty   (id_empty),
		.full    (id_full)
	);

	//////////////////////////////////////////////////////////////////////
	// Rank reads
	//////////////////////////////////////////////////////////////////////

	assign cmd.kind = RD_EDGE_DATA;
	// Head stays put until the pop, so addr is stable during req
	assign cmd.addr = ADDR_W'(id_head);
	assign edge_id_pop = cmd.req && cmd.ack;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cmd.req       <= 1'b0;
			contrib_valid <= 1'b0;
		end else begin
			if (!id_empty && !cmd.req && !cmd.ack) begin
				cmd.req <= 1'b1;
			end else if (cmd.ack) begin
				cmd.req <= 1'b0;
			end
			contrib_valid <= data_rsp;
		end
	end

	always_ff @(posedge clock) begin
		if (data_rsp) begin
			contrib <= rsp_data;
		end
	end

	assert property (@(posedge clock) disable iff (!rstn) !(id_push && id_full))
		else $error("neighbor id arrived with the buffer full");

endmodule

// ==== hw/read_cmd_arbiter.sv ====
`timescale 1ns/1ps

module read_cmd_arbiter
	import pr_pkg::*;
(
	input  logic              clock,
	input  logic              rstn,
	input  logic              cmd_ack,
	cmd_port_if.sink          edge_job,
	cmd_port_if.sink          edge_data,
	output logic              cmd_req,
	output read_kind_t        cmd_kind,
	output logic [ADDR_W-1:0] cmd_addr
);

	logic [1:0] pending;
	logic [1:0] grant;
	logic       last;
	logic       push;
	logic       launch;
	logic       q_empty;
	logic       q_full;
	read_cmd_t  push_cmd;
	read_cmd_t  q_head;

	//////////////////////////////////////////////////////////////////////
	// Round-robin grant into the command queue
	//////////////////////////////////////////////////////////////////////

	assign pending[0] = edge_job.req && !edge_job.ack;
	assign pending[1] = edge_data.req && !edge_data.ack;

	// last set means source 1 won last time
	always_comb begin
		grant = 2'b00;
		if (!q_full) begin
			if (pending[0] && (!pending[1] || last)) begin
				grant[0] = 1'b1;
			end else if (pending[1]) begin
				grant[1] = 1'b1;
			end
		end
	end

	assign push     = |grant;
	assign push_cmd = grant[0] ?
		read_cmd_t'{kind: read_kind_t'(edge_job.kind), addr: edge_job.addr} :
		read_cmd_t'{kind: read_kind_t'(edge_data.kind), addr: edge_data.addr};

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			last          <= 1'b1;
			edge_job.ack  <= 1'b0;
			edge_data.ack <= 1'b0;
		end else begin
			if (push) begin
				last <= grant[1];
			end
			// Ack rises with the push and falls after req
			if (grant[0]) begin
				edge_job.ack <= 1'b1;
			end else if (!edge_job.req) begin
				edge_job.ack <= 1'b0;
			end
			if (grant[1]) begin
				edge_data.ack <= 1'b1;
			end else if (!edge_data.req) begin
				edge_data.ack <= 1'b0;
			end
		end
	end

	sync_fifo #(
		.T    (read_cmd_t),
		.DEPTH(CMD_FIFO_DEPTH)
	) cmd_fifo_inst (
		.clock   (clock),
		.rstn    (rstn),
		.push    (push),
		.data_in (push_cmd),
		.pop     (launch),
		.data_out(q_head),
		.empty   (q_empty),
		.full    (q_full)
	);

	//////////////////////////////////////////////////////////////////////
	// Outgoing command port
	//////////////////////////////////////////////////////////////////////

	assign launch = !q_empty && !cmd_req && !cmd_ack;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cmd_req <= 1'b0;
		end else if (launch) begin
			cmd_req <= 1'b1;
		end else if (cmd_ack) begin
			cmd_req <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (launch) begin
			cmd_kind <= q_head.kind;
			cmd_addr <= q_head.addr;
		end
	end

	assert property (@(posedge clock) disable iff (!rstn)
		edge_job.req && $past(edge_job.req) |-> $stable({edge_job.kind, edge_job.addr}))
		else $error("edge job command changed while req high");

	assert property (@(posedge clock) disable iff (!rstn)
		edge_data.req && $past(edge_data.req) |-> $stable({edge_data.kind, edge_data.addr}))
		else $error("edge data command changed while req high");

endmodule

// ==== hw/rank_sum_kernel.sv ====
`timescale 1ns/1ps

module rank_sum_kernel
	import pr_pkg::*;
(
	input  logic               clock,
	input  logic               rstn,
	input  logic               start,
	input  vertex_job_t        job,
	input  logic               contrib_valid,
	input  logic [RANK_W-1:0]  contrib,
	input  logic               wr_ack,
	output logic               vertex_done,
	output logic               wr_req,
	output vertex_id_t         wr_vertex,
	output logic [RANK_W-1:0]  wr_sum,
	output logic [COUNT_W-1:0] vertex_count,
	output logic [COUNT_W-1:0] edge_count
);

	logic                active;
	logic [VERTEX_W-1:0] received;
	logic [RANK_W-1:0]   sum;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			active       <= 1'b0;
			received     <= '0;
			wr_req       <= 1'b0;
			vertex_done  <= 1'b0;
			vertex_count <= '0;
			edge_count   <= '0;
		end else begin
			vertex_done <= 1'b0;
			if (start) begin
				active   <= 1'b1;
				received <= '0;
			end else begin
				if (contrib_valid) begin
					received <= received + 1'b1;
				end
				// All contributions in and the previous write fully closed
				if (active && received == job.degree && !wr_req && !wr_ack) begin
					active <= 1'b0;
					wr_req <= 1'b1;
				end
			end
			if (wr_req && wr_ack) begin
				wr_req       <= 1'b0;
				vertex_done  <= 1'b1;
				vertex_count <= vertex_count + 1'b1;
			end
			if (contrib_valid) begin
				edge_count <= edge_count + 1'b1;
			end
		end
	end

	// Unsigned sum that wraps at 32 bits
	always_ff @(posedge clock) begin
		if (start) begin
			sum <= '0;
		end else if (contrib_valid) begin
			sum <= sum + contrib;
		end
	end

	assign wr_vertex = job.id;
	assign wr_sum    = sum;

	assert property (@(posedge clock) disable iff (!rstn) contrib_valid |-> active && !start)
		else $error("contribution outside an active vertex");

endmodule

// ==== hw/pagerank_cu.sv ====
`timescale 1ns/1ps

module pagerank_cu
	import pr_pkg::*;
(
	input  logic                clock,
	input  logic                rstn,
	input  logic                vtx_req,
	output logic                vtx_ack,
	input  vertex_id_t          vtx_id,
	input  logic [ADDR_W-1:0]   vtx_edge_base,
	input  logic [VERTEX_W-1:0] vtx_degree,
	output logic                cmd_req,
	input  logic                cmd_ack,
	output read_kind_t          cmd_kind,
	output logic [ADDR_W-1:0]   cmd_addr,
	input  logic                rsp_valid,
	input  read_kind_t          rsp_kind,
	input  logic [RANK_W-1:0]   rsp_data,
	output logic                wr_req,
	input  logic                wr_ack,
	output vertex_id_t          wr_vertex,
	output logic [RANK_W-1:0]   wr_sum,
	output logic [COUNT_W-1:0]  vertex_count,
	output logic [COUNT_W-1:0]  edge_count
);

	logic              start;
	vertex_job_t       job;
	logic              vertex_done;
	logic              edge_id_pop;
	logic              contrib_valid;
	logic [RANK_W-1:0] contrib;

	cmd_port_if #(.AW(ADDR_W)) edge_job_cmd ();
	cmd_port_if #(.AW(ADDR_W)) edge_data_cmd ();

	//////////////////////////////////////////////////////////////////////
	// Vertex intake and edge reads
	//////////////////////////////////////////////////////////////////////

	vertex_job_control vertex_job_control_inst (
		.clock        (clock),
		.rstn         (rstn),
		.vtx_req      (vtx_req),
		.vtx_id       (vtx_id),
		.vtx_edge_base(vtx_edge_base),
		.vtx_degree   (vtx_degree),
		.vertex_done  (vertex_done),
		.vtx_ack      (vtx_ack),
		.start        (start),
		.job          (job)
	);

	edge_job_control edge_job_control_inst (
		.clock      (clock),
		.rstn       (rstn),
		.start      (start),
		.job        (job),
		.edge_id_pop(edge_id_pop),
		.cmd        (edge_job_cmd.source)
	);

	edge_data_control edge_data_control_inst (
		.clock        (clock),
		.rstn         (rstn),
		.rsp_valid    (rsp_valid),
		.rsp_kind     (rsp_kind),
		.rsp_data     (rsp_data),
		.edge_id_pop  (edge_id_pop),
		.contrib_valid(contrib_valid),
		.contrib      (contrib),
		.cmd          (edge_data_cmd.source)
	);

	//////////////////////////////////////////////////////////////////////
	// Shared command path and sum
	//////////////////////////////////////////////////////////////////////

	read_cmd_arbiter read_cmd_arbiter_inst (
		.clock    (clock),
		.rstn     (rstn),
		.cmd_ack  (cmd_ack),
		.edge_job (edge_job_cmd.sink),
		.edge_data(edge_data_cmd.sink),
		.cmd_req  (cmd_req),
		.cmd_kind (cmd_kind),
		.cmd_addr (cmd_addr)
	);

	rank_sum_kernel rank_sum_kernel_inst (
		.clock        (clock),
		.rstn         (rstn),
		.start        (start),
		.job          (job),
		.contrib_valid(contrib_valid),
		.contrib      (contrib),
		.wr_ack       (wr_ack),
		.vertex_done  (vertex_done),
		.wr_req       (wr_req),
		.wr_vertex    (wr_vertex),
		.wr_sum       (wr_sum),
		.vertex_count (vertex_count),
		.edge_count   (edge_count)
	);

endmodule

// ==== tb/tb_pagerank_cu.sv ====
`timescale 1ns/1ps

module tb_pagerank_cu
	import pr_pkg::*;
();

	localparam int MAX_DEGREE     = 9;
	// Four queued plus one active, so the sixth job meets a full queue
	localparam int QUEUED_JOBS    = 6;
	localparam int TOTAL_EDGES    = 5 + QUEUED_JOBS * MAX_DEGREE;
	localparam int TOTAL_VERTICES = 2 + QUEUED_JOBS;
	localparam int CYCLE_LIMIT    = 2 * (60 * TOTAL_EDGES + 40 * TOTAL_VERTICES);

	logic                clock = 1'b0;
	logic                rstn;
	logic                vtx_req;
	logic                vtx_ack;
	vertex_id_t          vtx_id;
	logic [ADDR_W-1:0]   vtx_edge_base;
	logic [VERTEX_W-1:0] vtx_degree;
	logic                cmd_req;
	logic                cmd_ack;
	read_kind_t          cmd_kind;
	logic [ADDR_W-1:0]   cmd_addr;
	logic                rsp_valid;
	read_kind_t          rsp_kind;
	logic [RANK_W-1:0]   rsp_data;
	logic                wr_req;
	logic                wr_ack;
	vertex_id_t          wr_vertex;
	logic [RANK_W-1:0]   wr_sum;
	logic [COUNT_W-1:0]  vertex_count;
	logic [COUNT_W-1:0]  edge_count;

	int                seed = 32'h913a;
	int                cycles = 0;
	int                ack_wait = -1;
	int                wr_wait = 0;
	int                wr_delay = 1;
	int                total_vertices = 0;
	int                total_edges = 0;
	logic [ADDR_W-1:0] job_log [$];
	logic [ADDR_W-1:0] data_log [$];
	read_kind_t        rsp_kind_q [$];
	logic [RANK_W-1:0] rsp_data_q [$];
	int                rsp_wait_q [$];
	vertex_id_t        wr_vertex_log [$];
	logic [RANK_W-1:0] wr_sum_log [$];

	always #50 clock = ~clock;

	pagerank_cu pagerank_cu_inst (.*);

	//////////////////////////////////////////////////////////////////////
	// Reference rules and helpers
	//////////////////////////////////////////////////////////////////////

	function automatic vertex_id_t neighbor(input logic [ADDR_W-1:0] a);
		logic [31:0] t;
		t = 32'(a) * 32'd7 + 32'd3;
		return {8'h00, t[7:0]};
	endfunction

	function automatic logic [RANK_W-1:0] rank(input vertex_id_t n);
		return 32'(n) * 32'd3 + 32'd1;
	endfunction

	function automatic logic [RANK_W-1:0] expected_sum(input logic [ADDR_W-1:0] base,
		input logic [VERTEX_W-1:0] degree);
		logic [RANK_W-1:0] sum;
		sum = '0;
		for (int i = 0; i < int'(degree); i++) begin
			sum = sum + rank(neighbor(base + ADDR_W'(i)));
		end
		return sum;
	endfunction

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("Error at %0d ns: %s, got %0h, expected %0h",
				$time, what, got, exp));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Memory model and write sink stepped once per falling edge
	//////////////////////////////////////////////////////////////////////

	task automatic accept_command();
		rsp_kind_q.push_back(cmd_kind);
		rsp_wait_q.push_back(1 + rand_below(4));
		if (cmd_kind == RD_EDGE_JOB) begin
			job_log.push_back(cmd_addr);
			rsp_data_q.push_back(RANK_W'(neighbor(cmd_addr)));
		end else begin
			data_log.push_back(cmd_addr);
			rsp_data_q.push_back(rank(cmd_addr));
		end
	endtask

	task automatic memory_step();
		int pick;
		int ready [$];
		rsp_valid = 1'b0;
		if (!rstn) begin
			cmd_ack  = 1'b0;
			ack_wait = -1;
		end else begin
			// Any ready response may go next, so order is scrambled
			foreach (rsp_wait_q[i]) begin
				if (rsp_wait_q[i] > 0) begin
					rsp_wait_q[i] = rsp_wait_q[i] - 1;
				end else begin
					ready.push_back(i);
				end
			end
			if (ready.size() > 0) begin
				pick      = ready[rand_below(ready.size())];
				rsp_valid = 1'b1;
				rsp_kind  = rsp_kind_q[pick];
				rsp_data  = rsp_data_q[pick];
				rsp_kind_q.delete(pick);
				rsp_data_q.delete(pick);
				rsp_wait_q.delete(pick);
			end
			if (cmd_ack) begin
				if (!cmd_req) begin
					cmd_ack = 1'b0;
				end
			end else if (cmd_req) begin
				if (ack_wait < 0) begin
					ack_wait = rand_below(4);
				end
				if (ack_wait == 0) begin
					accept_command();
					cmd_ack  = 1'b1;
					ack_wait = -1;
				end else begin
					ack_wait = ack_wait - 1;
				end
			end
		end
	endtask

	task automatic sink_step();
		if (!rstn) begin
			wr_ack  = 1'b0;
			wr_wait = 0;
		end else if (wr_ack) begin
			if (!wr_req) begin
				wr_ack = 1'b0;
			end
		end else if (wr_req) begin
			if (wr_wait < wr_delay) begin
				wr_wait = wr_wait + 1;
			end else begin
				wr_vertex_log.push_back(wr_vertex);
				wr_sum_log.push_back(wr_sum);
				wr_ack  = 1'b1;
				wr_wait = 0;
			end
		end
	endtask

	task automatic next_cycle();
		@(negedge clock);
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			fail_run($sformatf("Timeout: the run did not finish within %0d cycles",
				CYCLE_LIMIT));
		end
		memory_step();
		sink_step();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic clear_logs();
		job_log.delete();
		data_log.delete();
		wr_vertex_log.delete();
		wr_sum_log.delete();
	endtask

	// Four-phase job handshake that reports the writes seen when ack rose
	task automatic send_vertex(input vertex_id_t id, input logic [ADDR_W-1:0] base,
		input logic [VERTEX_W-1:0] degree, output int writes_seen);
		vtx_req       = 1'b1;
		vtx_id        = id;
		vtx_edge_base = base;
		vtx_degree    = degree;
		next_cycle();
		while (!vtx_ack) begin
			next_cycle();
		end
		writes_seen = wr_sum_log.size();
		vtx_req     = 1'b0;
		while (vtx_ack) begin
			next_cycle();
		end
		total_vertices++;
		total_edges += int'(degree);
	endtask

	task automatic wait_writes(input int n);
		while (wr_sum_log.size() < n) begin
			next_cycle();
		end
		while (wr_req || wr_ack) begin
			next_cycle();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////////////////////////

	task automatic reset_outputs();
		check_value("vtx_ack after reset", 32'(vtx_ack), 32'd0);
		check_value("cmd_req after reset", 32'(cmd_req), 32'd0);
		check_value("wr_req after reset", 32'(wr_req), 32'd0);
		check_value("vertex_count after reset", vertex_count, 32'd0);
		check_value("edge_count after reset", edge_count, 32'd0);
	endtask

	task automatic single_vertex();
		logic [ADDR_W-1:0] base;
		int                seen;
		int                hits;
		base = 16'h0040;
		clear_logs();
		wr_delay = 1;
		send_vertex(16'h0011, base, 16'd5, seen);
		wait_writes(1);
		repeat (10) next_cycle();
		check_value("single vertex write count", wr_sum_log.size(), 32'd1);
		check_value("single vertex id", 32'(wr_vertex_log[0]), 32'h0011);
		check_value("single vertex sum", wr_sum_log[0], expected_sum(base, 16'd5));
		check_value("edge job read count", job_log.size(), 32'd5);
		check_value("edge data read count", data_log.size(), 32'd5);
		for (int i = 0; i < 5; i++) begin
			check_value("edge job read address", 32'(job_log[i]), 32'(base + ADDR_W'(i)));
			hits = 0;
			foreach (data_log[j]) begin
				if (data_log[j] == neighbor(base + ADDR_W'(i))) begin
					hits++;
				end
			end
			check_value("edge data reads of one neighbor", hits, 32'd1);
		end
	endtask

	task automatic zero_degree_vertex();
		int seen;
		clear_logs();
		send_vertex(16'h0022, 16'h1234, 16'd0, seen);
		wait_writes(1);
		check_value("zero degree write count", wr_sum_log.size(), 32'd1);
		check_value("zero degree vertex id", 32'(wr_vertex_log[0]), 32'h0022);
		check_value("zero degree sum", wr_sum_log[0], 32'd0);
		check_value("zero degree read commands", job_log.size() + data_log.size(), 32'd0);
	endtask

	task automatic queued_vertices();
		vertex_id_t          ids [QUEUED_JOBS];
		logic [ADDR_W-1:0]   bases [QUEUED_JOBS];
		logic [VERTEX_W-1:0] degrees [QUEUED_JOBS];
		int                  seen;
		clear_logs();
		wr_delay = 10;
		for (int k = 0; k < QUEUED_JOBS; k++) begin
			ids[k]     = 16'(32'h0100 + k);
			bases[k]   = ADDR_W'($random(seed));
			degrees[k] = VERTEX_W'(1 + rand_below(MAX_DEGREE));
			send_vertex(ids[k], bases[k], degrees[k], seen);
			if (k == QUEUED_JOBS - 1) begin
				check_value("job accepted while the queue was full", 32'(seen > 0), 32'd1);
			end
		end
		wait_writes(QUEUED_JOBS);
		check_value("queued write count", wr_sum_log.size(), QUEUED_JOBS);
		for (int k = 0; k < QUEUED_JOBS; k++) begin
			check_value("queued vertex id", 32'(wr_vertex_log[k]), 32'(ids[k]));
			check_value("queued vertex sum", wr_sum_log[k], expected_sum(bases[k], degrees[k]));
		end
	endtask

	task automatic counter_totals();
		check_value("vertex_count", vertex_count, 32'(total_vertices));
		check_value("edge_count", edge_count, 32'(total_edges));
	endtask

	initial begin
		rstn          = 1'b0;
		vtx_req       = 1'b0;
		vtx_id        = '0;
		vtx_edge_base = '0;
		vtx_degree    = '0;
		cmd_ack       = 1'b0;
		rsp_valid     = 1'b0;
		rsp_kind      = RD_EDGE_JOB;
		rsp_data      = '0;
		wr_ack        = 1'b0;
		repeat (2) next_cycle();
		rstn = 1'b1;
		reset_outputs();
		single_vertex();
		zero_degree_vertex();
		queued_vertices();
		counter_totals();
		$display("*** PASSED ***");
		$finish;
	end

endmodule

// ==== files.f ====
hw/pr_pkg.sv
hw/cmd_port_if.sv
hw/sync_fifo.sv
hw/vertex_job_control.sv
hw/edge_job_control.sv
hw/edge_data_control.sv
hw/read_cmd_arbiter.sv
hw/rank_sum_kernel.sv
hw/pagerank_cu.sv
tb/tb_pagerank_cu.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_pagerank_cu -f files.f -Mdir obj_dir

# The log decides the result
./obj_dir/Vtb_pagerank_cu > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** PASSED ***" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
